/* logic/simd_defines.svh */
`ifndef SIMD_DEFINES_SVH
`define SIMD_DEFINES_SVH

// Operand and lane widths
`define SIMD_WORD_W 64
`define SIMD_HALF_W 32
`define SIMD_LANE_W 16

// Cycles from issue to a result entering the buffer
`define SIMD_PIPE_DEPTH 4

// Buffer entries, also the credits the issuer starts with
`define SIMD_BUF_DEPTH 8
`define SIMD_CREDIT_W 4

`endif

/* logic/simd_pkg.sv */
`include "simd_defines.svh"

package simd_pkg;

  // Low three bits pick the operation, bit 3 selects two 16-bit lanes per half
  typedef enum logic [3:0] {
    OP_ADD    = 4'h0,
    OP_SUB    = 4'h1,
    OP_MIN    = 4'h2,
    OP_MAX    = 4'h3,
    OP_CMP_LO = 4'h4,
    OP_CMP_HI = 4'h5
  } simd_op_t;

  // One half word, read as a single lane or as two narrow lanes
  typedef union packed {
    logic [`SIMD_HALF_W-1:0]      w32;
    logic [1:0][`SIMD_LANE_W-1:0] l16;
  } half_word_t;

  typedef struct packed {
    logic zero;
    logic carry;
    logic eq;
    logic lt;
  } simd_flags_t;

  // Operation with the lane-mode bit stripped
  function automatic simd_op_t op_base(simd_op_t op);
    return simd_op_t'({1'b0, op[2:0]});
  endfunction

  function automatic logic op_lane16(simd_op_t op);
    return op[3];
  endfunction

endpackage

/* logic/simd_half.sv */
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_half import simd_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        valid,
  input  simd_op_t    op,
  input  half_word_t  a,
  input  half_word_t  b,
  output half_word_t  res,
  output simd_flags_t flags
);

  logic s1_valid;
  logic s2_valid;
  logic s3_valid;

  simd_op_t   s1_op;
  simd_op_t   s2_op;
  half_word_t s1_a;
  half_word_t s1_b;
  half_word_t s2_a;
  half_word_t s2_b;

  logic [`SIMD_HALF_W:0]            sum32;
  logic [`SIMD_HALF_W:0]            dif32;
  logic [1:0][`SIMD_LANE_W:0]       sum16;
  logic [1:0][`SIMD_LANE_W:0]       dif16;
  half_word_t sum_n;
  half_word_t dif_n;
  logic [1:0] lt_n;
  logic       carry_n;
  logic       borrow_n;
  logic       eq_n;

  half_word_t s2_sum;
  half_word_t s2_dif;
  logic [1:0] s2_lt;
  logic       s2_carry;
  logic       s2_borrow;
  logic       s2_eq;

  half_word_t res_n;
  half_word_t s3_res;
  logic       s3_carry;
  logic       s3_eq;
  logic       s3_lt;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // Stage 1 operand capture
  always_ff @(posedge clk) begin
    if (valid) begin
      s1_op <= op;
      s1_a  <= a;
      s1_b  <= b;
    end
  end

  // Both lane widths are computed, the mode bit picks one
  always_comb begin
    sum32 = {1'b0, s1_a.w32} + {1'b0, s1_b.w32};
    dif32 = {1'b0, s1_a.w32} - {1'b0, s1_b.w32};
    for (int i = 0; i < 2; i++) begin
      sum16[i] = {1'b0, s1_a.l16[i]} + {1'b0, s1_b.l16[i]};
      dif16[i] = {1'b0, s1_a.l16[i]} - {1'b0, s1_b.l16[i]};
    end
    if (op_lane16(s1_op)) begin
      for (int i = 0; i < 2; i++) begin
        sum_n.l16[i] = sum16[i][`SIMD_LANE_W-1:0];
        dif_n.l16[i] = dif16[i][`SIMD_LANE_W-1:0];
        lt_n[i]      = $signed(s1_a.l16[i]) < $signed(s1_b.l16[i]);
      end
      carry_n  = sum16[1][`SIMD_LANE_W];
      borrow_n = dif16[1][`SIMD_LANE_W];
      eq_n     = s1_a.l16[1] == s1_b.l16[1];
    end else begin
      sum_n.w32 = sum32[`SIMD_HALF_W-1:0];
      dif_n.w32 = dif32[`SIMD_HALF_W-1:0];
      // Same compare copied to both lane slots so min and max stay per lane
      lt_n      = {2{$signed(s1_a.w32) < $signed(s1_b.w32)}};
      carry_n   = sum32[`SIMD_HALF_W];
      borrow_n  = dif32[`SIMD_HALF_W];
      eq_n      = s1_a.w32 == s1_b.w32;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_op     <= s1_op;
      s2_a      <= s1_a;
      s2_b      <= s1_b;
      s2_sum    <= sum_n;
      s2_dif    <= dif_n;
      s2_lt     <= lt_n;
      s2_carry  <= carry_n;
      s2_borrow <= borrow_n;
      s2_eq     <= eq_n;
    end
  end

  // Stage 3 result select, compares return the difference
  always_comb begin
    res_n = '0;
    case (op_base(s2_op))
      OP_ADD: res_n = s2_sum;
      OP_SUB, OP_CMP_LO, OP_CMP_HI: res_n = s2_dif;
      OP_MIN: begin
        for (int i = 0; i < 2; i++) begin
          res_n.l16[i] = s2_lt[i] ? s2_a.l16[i] : s2_b.l16[i];
        end
      end
      OP_MAX: begin
        for (int i = 0; i < 2; i++) begin
          res_n.l16[i] = s2_lt[i] ? s2_b.l16[i] : s2_a.l16[i];
        end
      end
      default: res_n = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      s3_res   <= res_n;
      // Carry only for add, every other op reports the borrow
      s3_carry <= (op_base(s2_op) == OP_ADD) ? s2_carry : s2_borrow;
      s3_eq    <= s2_eq;
      s3_lt    <= s2_lt[1];
    end
  end

  // Stage 4 flags for the topmost lane
  always_ff @(posedge clk) begin
    if (s3_valid) begin
      res         <= s3_res;
      flags.zero  <= s3_res.w32 == '0;
      flags.carry <= s3_carry;
      flags.eq    <= s3_eq;
      flags.lt    <= s3_lt;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    valid |-> op_base(op) inside {OP_ADD, OP_SUB, OP_MIN, OP_MAX, OP_CMP_LO, OP_CMP_HI});

endmodule

/* logic/simd_both.sv */
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_both import simd_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  simd_op_t                in_op,
  input  logic [`SIMD_WORD_W-1:0] in_a,
  input  logic [`SIMD_WORD_W-1:0] in_b,
  output logic                    pipe_valid,
  output logic [`SIMD_WORD_W-1:0] pipe_data,
  output simd_flags_t             pipe_flags
);

  localparam int DEPTH = `SIMD_PIPE_DEPTH;

  logic [DEPTH-1:0] valid_d;
  simd_op_t         op_d [DEPTH];
  half_word_t       res_lo;
  half_word_t       res_hi;
  simd_flags_t      flags_lo;
  simd_flags_t      flags_hi;

  simd_half half_lo (
    .clk   (clk),
    .rst   (rst),
    .valid (in_valid),
    .op    (in_op),
    .a     (in_a[`SIMD_HALF_W-1:0]),
    .b     (in_b[`SIMD_HALF_W-1:0]),
    .res   (res_lo),
    .flags (flags_lo)
  );

  simd_half half_hi (
    .clk   (clk),
    .rst   (rst),
    .valid (in_valid),
    .op    (in_op),
    .a     (in_a[`SIMD_WORD_W-1:`SIMD_HALF_W]),
    .b     (in_b[`SIMD_WORD_W-1:`SIMD_HALF_W]),
    .res   (res_hi),
    .flags (flags_hi)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_d <= '0;
    end else begin
      valid_d <= {valid_d[DEPTH-2:0], in_valid};
    end
  end

  // Opcode follows the halves so the flag source is known at the output
  always_ff @(posedge clk) begin
    op_d[0] <= in_op;
    for (int i = 1; i < DEPTH; i++) begin
      op_d[i] <= op_d[i-1];
    end
  end

  assign pipe_valid = valid_d[DEPTH-1];
  assign pipe_data  = {res_hi, res_lo};
  assign pipe_flags = (op_base(op_d[DEPTH-1]) == OP_CMP_HI) ? flags_hi : flags_lo;

  // Delay line and half pipelines stay in step
  assert property (@(posedge clk) disable iff (rst)
    pipe_valid == $past(half_lo.s3_valid) && pipe_valid == $past(half_hi.s3_valid));

endmodule

/* logic/result_buffer.sv */
`timescale 1ns/1ps
`include "simd_defines.svh"

module result_buffer import simd_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push,
  input  logic [`SIMD_WORD_W-1:0] push_data,
  input  simd_flags_t             push_flags,
  input  logic                    res_credit,
  output logic                    res_valid,
  output logic [`SIMD_WORD_W-1:0] res_data,
  output simd_flags_t             res_flags,
  output logic                    in_credit
);

  localparam int DEPTH = `SIMD_BUF_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CW    = `SIMD_CREDIT_W;

  logic [`SIMD_WORD_W-1:0] data_mem [DEPTH];
  simd_flags_t             flags_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CW-1:0]    count;
  logic [CW-1:0]    cred_cnt;
  logic             empty;
  logic             pop;
  logic             out_valid;

  assign empty = (count == '0);
  // An empty buffer forwards the incoming entry in the same cycle
  assign pop   = (!empty || push) && (cred_cnt != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr]  <= push_data;
      flags_mem[wr_ptr] <= push_flags;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      cred_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CW'(1);
        2'b01:   count <= count - CW'(1);
        default: count <= count;
      endcase
      case ({res_credit, pop})
        2'b10:   cred_cnt <= cred_cnt + CW'(1);
        2'b01:   cred_cnt <= cred_cnt - CW'(1);
        default: cred_cnt <= cred_cnt;
      endcase
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      res_data  <= empty ? push_data : data_mem[rd_ptr];
      res_flags <= empty ? push_flags : flags_mem[rd_ptr];
    end
  end

  // Leaving result frees an issue slot
  assign res_valid = out_valid;
  assign in_credit = out_valid;

  assert property (@(posedge clk) disable iff (rst)
    push |-> count != CW'(DEPTH));

  assert property (@(posedge clk) disable iff (rst)
    (res_credit && !pop) |-> cred_cnt != '1);

endmodule

/* logic/simd_unit_top.sv */
`timescale 1ns/1ps
`include "simd_defines.svh"

module simd_unit_top import simd_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  simd_op_t                in_op,
  input  logic [`SIMD_WORD_W-1:0] in_a,
  input  logic [`SIMD_WORD_W-1:0] in_b,
  output logic                    in_credit,
  input  logic                    res_credit,
  output logic                    res_valid,
  output logic [`SIMD_WORD_W-1:0] res_data,
  output simd_flags_t             res_flags
);

  logic                    pipe_valid;
  logic [`SIMD_WORD_W-1:0] pipe_data;
  simd_flags_t             pipe_flags;

  simd_both u_both (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .pipe_valid (pipe_valid),
    .pipe_data  (pipe_data),
    .pipe_flags (pipe_flags)
  );

  result_buffer u_buf (
    .clk        (clk),
    .rst        (rst),
    .push       (pipe_valid),
    .push_data  (pipe_data),
    .push_flags (pipe_flags),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_flags  (res_flags),
    .in_credit  (in_credit)
  );

endmodule

/* verif/tb_simd_model.svh */
`ifndef TB_SIMD_MODEL_SVH
`define TB_SIMD_MODEL_SVH

// One lane of width w, held in the low bits of x and y
function automatic void lane_model(input simd_op_t base, input logic [31:0] x,
                                   input logic [31:0] y, input int w, output logic [31:0] r,
                                   output logic carry, output logic eq, output logic lt);
  logic [32:0] sum;
  logic [31:0] mask;
  mask  = (w == 32) ? 32'hffff_ffff : 32'h0000_ffff;
  sum   = {1'b0, x} + {1'b0, y};
  eq    = x == y;
  // Differing sign bits mean the negative lane is the smaller one
  lt    = (x[w-1] != y[w-1]) ? x[w-1] : (x < y);
  carry = (base == OP_ADD) ? sum[w] : (x < y);
  case (base)
    OP_ADD:  r = sum[31:0] & mask;
    OP_MIN:  r = lt ? x : y;
    OP_MAX:  r = lt ? y : x;
    default: r = (x - y) & mask;
  endcase
endfunction

function automatic void half_model(input simd_op_t op, input half_word_t a,
                                   input half_word_t b, output half_word_t r,
                                   output simd_flags_t f);
  simd_op_t    base;
  logic [31:0] lr;
  logic        c;
  logic        e;
  logic        l;
  base = simd_op_t'({1'b0, op[2:0]});
  if (op[3]) begin
    for (int i = 0; i < 2; i++) begin
      lane_model(base, {16'h0, a.l16[i]}, {16'h0, b.l16[i]}, 16, lr, c, e, l);
      r.l16[i] = lr[15:0];
    end
  end else begin
    lane_model(base, a.w32, b.w32, 32, lr, c, e, l);
    r.w32 = lr;
  end
  // Last lane computed is the topmost one
  f.zero  = r.w32 == '0;
  f.carry = c;
  f.eq    = e;
  f.lt    = l;
endfunction

function automatic void model_op(input simd_op_t op, input logic [`SIMD_WORD_W-1:0] a,
                                 input logic [`SIMD_WORD_W-1:0] b,
                                 output logic [`SIMD_WORD_W-1:0] data,
                                 output simd_flags_t flags);
  half_word_t  r_lo;
  half_word_t  r_hi;
  simd_flags_t f_lo;
  simd_flags_t f_hi;
  half_model(op, a[31:0], b[31:0], r_lo, f_lo);
  half_model(op, a[63:32], b[63:32], r_hi, f_hi);
  data  = {r_hi, r_lo};
  flags = (simd_op_t'({1'b0, op[2:0]}) == OP_CMP_HI) ? f_hi : f_lo;
endfunction

`endif

/* verif/tb_simd_unit.sv */
`timescale 1ns/1ps
`include "simd_defines.svh"

module tb_simd_unit import simd_pkg::*; ();

  localparam int GRANT_NONE     = 0;
  localparam int GRANT_FREE     = 1;
  localparam int GRANT_RANDOM   = 2;
  localparam int DIRECTED_OPS   = 24;
  localparam int RAND_OPS       = 200;
  localparam int TOTAL_OPS      = DIRECTED_OPS + `SIMD_BUF_DEPTH + RAND_OPS;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS + 200;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    in_valid;
  simd_op_t                in_op;
  logic [`SIMD_WORD_W-1:0] in_a;
  logic [`SIMD_WORD_W-1:0] in_b;
  logic                    in_credit;
  logic                    res_credit;
  logic                    res_valid;
  logic [`SIMD_WORD_W-1:0] res_data;
  simd_flags_t             res_flags;

  logic [`SIMD_WORD_W-1:0] exp_data [$];
  simd_flags_t             exp_flags [$];
  int seed          = 32'h4c994c09;
  int grant_mode    = GRANT_NONE;
  int grants_total  = 0;
  int res_count     = 0;
  int credit_pulses = 0;
  int cycle_count   = 0;

  `include "tb_simd_model.svh"

  simd_unit_top DUT (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .in_credit  (in_credit),
    .res_credit (res_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_flags  (res_flags)
  );

  always #2 clk = ~clk;

  task automatic stop_with_failure;
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [`SIMD_WORD_W-1:0] exp,
                            input logic [`SIMD_WORD_W-1:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_flags(input string name, input simd_flags_t exp, input simd_flags_t act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  function automatic int credits_left();
    return `SIMD_BUF_DEPTH - exp_data.size() + credit_pulses;
  endfunction

  function automatic int consumer_credits();
    return grants_total - res_count;
  endfunction

  function automatic simd_op_t make_op(input simd_op_t base, input logic lane16);
    return simd_op_t'({lane16, base[2:0]});
  endfunction

  // Results are sampled 1 ns after the rising edge, away from the input edge
  always begin
    @(posedge clk);
    #1;
    if (!rst && in_credit) begin
      credit_pulses++;
    end
    if (!rst && res_valid) begin
      if (res_count >= exp_data.size()) begin
        $display("A result appeared with no operation outstanding");
        stop_with_failure();
      end else begin
        check_data("res_data", exp_data[res_count], res_data);
        check_flags("res_flags", exp_flags[res_count], res_flags);
        res_count++;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding",
               cycle_count, exp_data.size() - res_count);
      stop_with_failure();
    end
  end

  // Moves to the next falling edge and applies the consumer's grant policy
  task automatic next_cycle;
    logic [31:0] r;
    @(negedge clk);
    in_valid = 1'b0;
    case (grant_mode)
      GRANT_FREE: res_credit = grants_total < exp_data.size();
      GRANT_RANDOM: begin
        r = $random(seed);
        res_credit = r[0] && (consumer_credits() < `SIMD_BUF_DEPTH);
      end
      default: res_credit = 1'b0;
    endcase
    if (res_credit) begin
      grants_total++;
    end
  endtask

  task automatic issue_op(input simd_op_t op, input logic [`SIMD_WORD_W-1:0] a,
                          input logic [`SIMD_WORD_W-1:0] b);
    logic [`SIMD_WORD_W-1:0] data;
    simd_flags_t             flags;
    while (credits_left() == 0) begin
      next_cycle();
    end
    model_op(op, a, b, data, flags);
    exp_data.push_back(data);
    exp_flags.push_back(flags);
    in_valid = 1'b1;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    next_cycle();
  endtask

  task automatic grant_one;
    int target;
    target     = res_count + 1;
    res_credit = 1'b1;
    grants_total++;
    next_cycle();
    while (res_count < target) begin
      next_cycle();
    end
  endtask

  task automatic drain_results;
    while (res_count < exp_data.size()) begin
      next_cycle();
    end
    repeat (2 * `SIMD_PIPE_DEPTH) next_cycle();
  endtask

  task automatic test_add_sub_32;
    grant_mode = GRANT_FREE;
    // Low half carries out, high half must stay 1 + 2
    issue_op(OP_ADD, 64'h0000_0001_ffff_ffff, 64'h0000_0002_0000_0001);
    issue_op(OP_ADD, 64'h7fff_ffff_8000_0000, 64'h0000_0001_8000_0000);
    issue_op(OP_SUB, 64'h1000_0000_0000_0000, 64'h0000_0001_0000_0001);
    issue_op(OP_SUB, 64'h0000_0000_1234_5678, 64'h0000_0001_1234_5678);
    drain_results();
  endtask

  task automatic test_lanes_16;
    grant_mode = GRANT_FREE;
    issue_op(make_op(OP_ADD, 1'b1), 64'hffff_0001_8000_7fff, 64'h0001_ffff_8000_0001);
    issue_op(make_op(OP_ADD, 1'b1), 64'h1234_fffe_0000_ffff, 64'h0000_0003_0000_0001);
    issue_op(make_op(OP_SUB, 1'b1), 64'h0000_0001_0003_8000, 64'h0001_0002_0005_0001);
    issue_op(make_op(OP_SUB, 1'b1), 64'h7fff_0000_ffff_0010, 64'h8000_0001_ffff_0020);
    drain_results();
  endtask

  task automatic test_min_max;
    logic [`SIMD_WORD_W-1:0] a_set [2];
    logic [`SIMD_WORD_W-1:0] b_set [2];
    grant_mode = GRANT_FREE;
    a_set[0] = 64'hffff_fff0_0000_0005;
    b_set[0] = 64'h0000_0003_ffff_fffb;
    a_set[1] = 64'h8000_7fff_fffe_0002;
    b_set[1] = 64'h7fff_8000_0002_fffe;
    for (int i = 0; i < 2; i++) begin
      for (int l = 0; l < 2; l++) begin
        issue_op(make_op(OP_MIN, l[0]), a_set[i], b_set[i]);
        issue_op(make_op(OP_MAX, l[0]), a_set[i], b_set[i]);
      end
    end
    drain_results();
  endtask

  task automatic test_compare;
    logic [`SIMD_WORD_W-1:0] a_set [2];
    logic [`SIMD_WORD_W-1:0] b_set [2];
    grant_mode = GRANT_FREE;
    // High halves order one way, low halves the other or equal
    a_set[0] = 64'h0000_0005_0000_0009;
    b_set[0] = 64'h0000_0007_0000_0009;
    a_set[1] = 64'h8000_0000_0003_0001;
    b_set[1] = 64'h0001_0000_0001_0001;
    for (int i = 0; i < 2; i++) begin
      for (int l = 0; l < 2; l++) begin
        issue_op(make_op(OP_CMP_LO, l[0]), a_set[i], b_set[i]);
        issue_op(make_op(OP_CMP_HI, l[0]), a_set[i], b_set[i]);
      end
    end
    drain_results();
  endtask

  task automatic test_back_pressure;
    int res_before;
    int pulses_before;
    grant_mode = GRANT_NONE;
    check_count("issuer credits", `SIMD_BUF_DEPTH, credits_left());
    check_count("consumer credits", 0, consumer_credits());
    res_before    = res_count;
    pulses_before = credit_pulses;
    for (int i = 0; i < `SIMD_BUF_DEPTH; i++) begin
      issue_op(make_op(i[0] ? OP_SUB : OP_ADD, i[1]), {$random(seed), $random(seed)},
               {$random(seed), $random(seed)});
    end
    repeat (3 * `SIMD_PIPE_DEPTH) next_cycle();
    check_count("res_valid count", res_before, res_count);
    check_count("issuer credits", 0, credits_left());
    for (int i = 0; i < `SIMD_BUF_DEPTH; i++) begin
      grant_one();
    end
    check_count("in_credit pulses", pulses_before + `SIMD_BUF_DEPTH, credit_pulses);
  endtask

  task automatic test_random;
    logic [31:0]             r;
    logic [`SIMD_WORD_W-1:0] a;
    logic [`SIMD_WORD_W-1:0] b;
    int                      issued;
    issued     = 0;
    grant_mode = GRANT_RANDOM;
    while (issued < RAND_OPS) begin
      r = $random(seed);
      if (r[31:30] == 2'b00) begin
        next_cycle();
      end else begin
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        // Now and then equal operands so eq and zero get exercised
        if (r[4:2] == 3'b000) begin
          b = a;
        end else if (r[4:2] == 3'b001) begin
          b[31:0] = a[31:0];
        end
        issue_op(make_op(simd_op_t'(4'(r[15:8] % 8'd6)), r[16]), a, b);
        issued++;
      end
    end
    drain_results();
  endtask

  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_op      = OP_ADD;
    in_a       = '0;
    in_b       = '0;
    res_credit = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_add_sub_32();
    test_lanes_16();
    test_min_max();
    test_compare();
    test_back_pressure();
    test_random();
    if (res_count == exp_data.size()) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("%0d of %0d results never arrived", exp_data.size() - res_count,
               exp_data.size());
      stop_with_failure();
    end
  end

endmodule

/* filelist.f */
+incdir+logic
+incdir+verif
logic/simd_pkg.sv
logic/simd_half.sv
logic/simd_both.sv
logic/result_buffer.sv
logic/simd_unit_top.sv
verif/tb_simd_unit.sv

/* Makefile */
.PHONY: run clean

run: obj_dir/Vtb_simd_unit
	@out="$$(./obj_dir/Vtb_simd_unit)"; echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

obj_dir/Vtb_simd_unit: filelist.f $(wildcard logic/*.sv logic/*.svh verif/*.sv verif/*.svh)
	verilator --binary --assert -f filelist.f --top-module tb_simd_unit

clean:
	rm -rf obj_dir
